//--- design/csr_merge.sv
////////////////////
// CSR merge for the tracked CSR slots
// value = (wdata & wmask) | (rdata & ~wmask & rmask),
// with a change flag gated by the compare enables
////////////////////

`default_nettype none

module csr_merge (
   input  wire logic                                                         rvvi,
   input  wire logic                                                         rst_i,
   input  wire logic                                                         rvfi_valid_i,
   input  wire logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_wdata_i,
   input  wire logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_wmask_i,
   input  wire logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_rdata_i,
   input  wire logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_rmask_i,
   input  wire logic [rvvi_trace_pkg::NUM_CSR-1:0]                           csr_cmp_en_i,
   output logic      [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_value_o,
   output logic      [rvvi_trace_pkg::NUM_CSR-1:0]                           csr_wb_o
);

   logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] merged;
   logic [rvvi_trace_pkg::NUM_CSR-1:0]                           changed;

   ////////////////////
   // Per-slot merge

   always_comb begin
      for (int i = 0; i < rvvi_trace_pkg::NUM_CSR; i++) begin
         // Written bits win, then read bits that were sampled
         merged[i] = (csr_wdata_i[i] & csr_wmask_i[i]) |
                     (csr_rdata_i[i] & ~csr_wmask_i[i] & csr_rmask_i[i]);
         changed[i] = (merged[i] != csr_value_o[i]) && csr_cmp_en_i[i];
      end
   end

   ////////////////////
   // State update

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         csr_value_o <= '0;
         csr_wb_o    <= '0;
      end else if (rvfi_valid_i) begin
         csr_value_o <= merged;
         csr_wb_o    <= changed;
      end
   end

endmodule

`default_nettype wire

//--- design/fault_tracker.sv
////////////////////
// Bus fault tracker
// Load/store NMI level with its cause, and the
// instruction fetch fault level, per retirement
////////////////////

`default_nettype none

module fault_tracker (
   input  wire logic                                    rvvi,
   input  wire logic                                    rst_i,
   input  wire logic                                    rvfi_valid_i,
   input  wire logic [rvvi_trace_pkg::TRAP_W-1:0]       rvfi_trap_i,
   input  wire logic                                    intr_intr_i,
   input  wire logic                                    intr_interrupt_i,
   input  wire logic [rvvi_trace_pkg::INTR_CAUSE_W-1:0] intr_cause_i,
   output logic                                         nmi_o,
   output rvvi_trace_pkg::nmi_cause_e                   nmi_cause_o,
   output logic                                         ibus_fault_o
);

   logic       trap_trap;
   logic       trap_exception;
   logic [5:0] trap_exc_cause;
   logic       nmi_hit;
   logic       fetch_hit;

   ////////////////////
   // Decode

   // Trap word fields
   assign trap_trap      = rvfi_trap_i[0];
   assign trap_exception = rvfi_trap_i[1];
   assign trap_exc_cause = rvfi_trap_i[8:3];

   assign nmi_hit = intr_intr_i && intr_interrupt_i &&
                    ((intr_cause_i == rvvi_trace_pkg::NMI_LOAD) ||
                     (intr_cause_i == rvvi_trace_pkg::NMI_STORE));

   assign fetch_hit = trap_trap && trap_exception &&
                      (trap_exc_cause == rvvi_trace_pkg::EXC_FETCH_FAULT);

   ////////////////////
   // Levels

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         nmi_o        <= 1'b0;
         nmi_cause_o  <= rvvi_trace_pkg::NMI_LOAD;
         ibus_fault_o <= 1'b0;
      end else if (rvfi_valid_i) begin
         nmi_o        <= nmi_hit;
         ibus_fault_o <= fetch_hit;
         // Cause keeps the last NMI seen
         if (nmi_hit) begin
            nmi_cause_o <= rvvi_trace_pkg::nmi_cause_e'(intr_cause_i);
         end
      end
   end

endmodule

`default_nettype wire

//--- design/halt_stretch.sv
////////////////////
// Debug halt request stretcher
// Holds haltreq for a set number of
// cycles after the request drops
////////////////////

`default_nettype none

module halt_stretch #(
   parameter int HOLD_W = 4
) (
   input  wire logic              rvvi,
   input  wire logic              rst_i,
   input  wire logic              debug_req_i,
   input  wire logic [HOLD_W-1:0] halt_hold_i,
   output logic                   haltreq_o
);

   logic [HOLD_W-1:0] hold_cnt;

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         hold_cnt  <= '0;
         haltreq_o <= 1'b0;
      end else if (debug_req_i) begin
         // Reload while the request is up
         hold_cnt  <= halt_hold_i;
         haltreq_o <= 1'b1;
      end else if (hold_cnt != '0) begin
         hold_cnt  <= hold_cnt - 1'b1;
         haltreq_o <= 1'b1;
      end else begin
         haltreq_o <= 1'b0;
      end
   end

   a_req_to_halt : assert property (
      @(posedge rvvi) disable iff (rst_i)
      debug_req_i |=> haltreq_o
   );

endmodule

`default_nettype wire

//--- design/irq_change_detect.sv
////////////////////
// Interrupt change detector
// Pulses on any change of the interrupt lines
// and forwards lines 3, 7, 11 and 16..31
////////////////////

`default_nettype none

module irq_change_detect (
   input  wire logic                                 rvvi,
   input  wire logic                                 rst_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]      irq_i,
   output logic                                      irq_change_o,
   output logic      [rvvi_trace_pkg::IRQ_MAP_W-1:0] irq_lines_o
);

   logic [rvvi_trace_pkg::XLEN-1:0]      irq_prev;
   logic                                 irq_diff;
   logic [rvvi_trace_pkg::IRQ_MAP_W-1:0] irq_mapped;

   assign irq_diff = (irq_i != irq_prev);

   // Software, timer, external, then the 16 local lines
   assign irq_mapped = {irq_i[31:16], irq_i[11], irq_i[7], irq_i[3]};

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         irq_prev     <= '0;
         irq_change_o <= 1'b0;
         irq_lines_o  <= '0;
      end else begin
         irq_prev     <= irq_i;
         irq_change_o <= irq_diff;
         if (irq_diff) begin
            irq_lines_o <= irq_mapped;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/retire_capture.sv
////////////////////
// Retirement capture
// Registers one RVFI record per cycle and
// decodes rd into a one-hot writeback mask
////////////////////

`default_nettype none

module retire_capture (
   input  wire logic                                  rvvi,
   input  wire logic                                  rst_i,
   input  wire logic                                  rvfi_valid_i,
   input  wire logic [63:0]                           rvfi_order_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]       rvfi_insn_i,
   input  wire logic [rvvi_trace_pkg::TRAP_W-1:0]     rvfi_trap_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]       rvfi_pc_rdata_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]       rvfi_pc_wdata_i,
   input  wire logic [rvvi_trace_pkg::GPR_ADDR_W-1:0] rvfi_rd_addr_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]       rvfi_rd_wdata_i,
   output logic                                       valid_o,
   output logic      [63:0]                           order_o,
   output logic      [rvvi_trace_pkg::XLEN-1:0]       insn_o,
   output logic      [rvvi_trace_pkg::TRAP_W-1:0]     trap_o,
   output logic      [rvvi_trace_pkg::XLEN-1:0]       pc_rdata_o,
   output logic      [rvvi_trace_pkg::XLEN-1:0]       pc_wdata_o,
   output logic      [rvvi_trace_pkg::XLEN-1:0]       x_wdata_o,
   output logic      [rvvi_trace_pkg::NUM_GPR-1:0]    x_wb_o
);

   logic [rvvi_trace_pkg::NUM_GPR-1:0] wb_mask;

   // x0 never reports a write
   always_comb begin
      wb_mask = '0;
      if (rvfi_valid_i && (rvfi_rd_addr_i != '0)) begin
         wb_mask[rvfi_rd_addr_i] = 1'b1;
      end
   end

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         valid_o <= 1'b0;
         x_wb_o  <= '0;
      end else begin
         valid_o <= rvfi_valid_i;
         x_wb_o  <= wb_mask;
      end
   end

   // Record payload
   always_ff @(posedge rvvi) begin
      order_o    <= rvfi_order_i;
      insn_o     <= rvfi_insn_i;
      trap_o     <= rvfi_trap_i;
      pc_rdata_o <= rvfi_pc_rdata_i;
      pc_wdata_o <= rvfi_pc_wdata_i;
      x_wdata_o  <= rvfi_rd_wdata_i;
   end

   // At most one register written, and only by a retired record
   a_x_wb_onehot : assert property (
      @(posedge rvvi) disable iff (rst_i)
      $onehot0(x_wb_o) && ((x_wb_o == '0) || valid_o)
   );

endmodule

`default_nettype wire

//--- design/rvvi_trace_pkg.sv
////////////////////
// RVVI trace adapter shared definitions
// Widths, CSR slot and NMI cause encodings,
// configuration register map and reset defaults
////////////////////

`default_nettype none

package rvvi_trace_pkg;

   ////////////////////
   // Widths

   localparam int XLEN         = 32;
   localparam int NUM_GPR      = 32;
   localparam int GPR_ADDR_W   = 5;
   localparam int INTR_CAUSE_W = 11;

   // Trap word layout
   //   [0] trap, [1] exception, [2] debug, [8:3] exception cause,
   //   [11:9] debug cause, [13:12] cause type
   localparam int TRAP_W = 14;

   ////////////////////
   // Tracked CSR slots

   typedef enum logic [2:0] {
      MSTATUS  = 3'd0,
      MIE      = 3'd1,
      MTVEC    = 3'd2,
      MSCRATCH = 3'd3,
      MEPC     = 3'd4,
      MCAUSE   = 3'd5,
      MTVAL    = 3'd6,
      MIP      = 3'd7
   } csr_idx_e;

   // Last slot sets the count
   localparam int NUM_CSR = int'(MIP) + 1;

   ////////////////////
   // Cause codes

   typedef enum logic [INTR_CAUSE_W-1:0] {
      NMI_LOAD  = 11'd1024,
      NMI_STORE = 11'd1025
   } nmi_cause_e;

   // Instruction fetch bus fault
   localparam logic [5:0] EXC_FETCH_FAULT = 6'd48;

   ////////////////////
   // Configuration registers

   typedef enum logic {
      CFG_HALT_HOLD  = 1'b0,
      CFG_CSR_CMP_EN = 1'b1
   } cfg_reg_e;

   localparam int HALT_HOLD_DEFAULT = 5;

   // MSTATUS, MEPC and MIP are not compared by default
   localparam logic [NUM_CSR-1:0] CSR_CMP_EN_DEFAULT =
      ~((NUM_CSR'(1) << MSTATUS) | (NUM_CSR'(1) << MEPC) | (NUM_CSR'(1) << MIP));

   // Forwarded interrupt lines 3, 7, 11 and 16..31
   localparam int IRQ_MAP_W = 19;

endpackage

`default_nettype wire

//--- design/rvvi_trace_top.sv
////////////////////
// RVVI trace adapter top level
// RVFI retirement record in, reference
// model trace state out
////////////////////

`default_nettype none

module rvvi_trace_top #(
   parameter int HOLD_W = 4
) (
   input  wire logic                                                         rvvi,
   input  wire logic                                                         rst_i,
   // Retirement record
   input  wire logic                                                         rvfi_valid_i,
   input  wire logic [63:0]                                                  rvfi_order_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]                              rvfi_insn_i,
   input  wire logic [rvvi_trace_pkg::TRAP_W-1:0]                            rvfi_trap_i,
   input  wire logic                                                         rvfi_intr_intr_i,
   input  wire logic                                                         rvfi_intr_interrupt_i,
   input  wire logic [rvvi_trace_pkg::INTR_CAUSE_W-1:0]                      rvfi_intr_cause_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]                              rvfi_pc_rdata_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]                              rvfi_pc_wdata_i,
   input  wire logic [rvvi_trace_pkg::GPR_ADDR_W-1:0]                        rvfi_rd_addr_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]                              rvfi_rd_wdata_i,
   // Tracked CSRs
   input  wire logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_wdata_i,
   input  wire logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_wmask_i,
   input  wire logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_rdata_i,
   input  wire logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_rmask_i,
   // Debug, interrupts, configuration
   input  wire logic                                                         debug_req_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]                              irq_i,
   input  wire logic                                                         cfg_we_i,
   input  wire rvvi_trace_pkg::cfg_reg_e                                     cfg_addr_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]                              cfg_wdata_i,
   // Trace state
   output logic                                                              valid_o,
   output logic      [63:0]                                                  order_o,
   output logic      [rvvi_trace_pkg::XLEN-1:0]                              insn_o,
   output logic      [rvvi_trace_pkg::TRAP_W-1:0]                            trap_o,
   output logic      [rvvi_trace_pkg::XLEN-1:0]                              pc_rdata_o,
   output logic      [rvvi_trace_pkg::XLEN-1:0]                              pc_wdata_o,
   output logic      [rvvi_trace_pkg::XLEN-1:0]                              x_wdata_o,
   output logic      [rvvi_trace_pkg::NUM_GPR-1:0]                           x_wb_o,
   output logic      [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_value_o,
   output logic      [rvvi_trace_pkg::NUM_CSR-1:0]                           csr_wb_o,
   output logic                                                              haltreq_o,
   output logic                                                              nmi_o,
   output rvvi_trace_pkg::nmi_cause_e                                        nmi_cause_o,
   output logic                                                              ibus_fault_o,
   output logic                                                              irq_change_o,
   output logic      [rvvi_trace_pkg::IRQ_MAP_W-1:0]                         irq_lines_o
);

   logic [HOLD_W-1:0]                  halt_hold;
   logic [rvvi_trace_pkg::NUM_CSR-1:0] csr_cmp_en;

   trace_cfg_regs #(.HOLD_W(HOLD_W)) u_cfg (
      .rvvi, .rst_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
      .halt_hold_o  (halt_hold),
      .csr_cmp_en_o (csr_cmp_en)
   );

   retire_capture u_capture (
      .rvvi, .rst_i, .rvfi_valid_i, .rvfi_order_i, .rvfi_insn_i, .rvfi_trap_i,
      .rvfi_pc_rdata_i, .rvfi_pc_wdata_i, .rvfi_rd_addr_i, .rvfi_rd_wdata_i,
      .valid_o, .order_o, .insn_o, .trap_o, .pc_rdata_o, .pc_wdata_o,
      .x_wdata_o, .x_wb_o
   );

   csr_merge u_csr (
      .rvvi, .rst_i, .rvfi_valid_i,
      .csr_wdata_i, .csr_wmask_i, .csr_rdata_i, .csr_rmask_i,
      .csr_cmp_en_i (csr_cmp_en),
      .csr_value_o, .csr_wb_o
   );

   halt_stretch #(.HOLD_W(HOLD_W)) u_halt (
      .rvvi, .rst_i, .debug_req_i,
      .halt_hold_i (halt_hold),
      .haltreq_o
   );

   fault_tracker u_fault (
      .rvvi, .rst_i, .rvfi_valid_i, .rvfi_trap_i,
      .intr_intr_i      (rvfi_intr_intr_i),
      .intr_interrupt_i (rvfi_intr_interrupt_i),
      .intr_cause_i     (rvfi_intr_cause_i),
      .nmi_o, .nmi_cause_o, .ibus_fault_o
   );

   irq_change_detect u_irq (
      .rvvi, .rst_i, .irq_i, .irq_change_o, .irq_lines_o
   );

endmodule

`default_nettype wire

//--- design/trace_cfg_regs.sv
////////////////////
// Trace configuration registers
// Halt hold length and CSR compare enables,
// written through a plain strobe port
////////////////////

`default_nettype none

module trace_cfg_regs #(
   parameter int HOLD_W = 4
) (
   input  wire logic                               rvvi,
   input  wire logic                               rst_i,
   input  wire logic                               cfg_we_i,
   input  wire rvvi_trace_pkg::cfg_reg_e           cfg_addr_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0]    cfg_wdata_i,
   output logic      [HOLD_W-1:0]                  halt_hold_o,
   output logic      [rvvi_trace_pkg::NUM_CSR-1:0] csr_cmp_en_o
);

   ////////////////////
   // Register file

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         halt_hold_o  <= HOLD_W'(rvvi_trace_pkg::HALT_HOLD_DEFAULT);
         csr_cmp_en_o <= rvvi_trace_pkg::CSR_CMP_EN_DEFAULT;
      end else if (cfg_we_i) begin
         // Low bits of the data only
         case (cfg_addr_i)
            rvvi_trace_pkg::CFG_HALT_HOLD: begin
               halt_hold_o <= cfg_wdata_i[HOLD_W-1:0];
            end
            rvvi_trace_pkg::CFG_CSR_CMP_EN: begin
               csr_cmp_en_o <= cfg_wdata_i[rvvi_trace_pkg::NUM_CSR-1:0];
            end
         endcase
      end
   end

   ////////////////////
   // Checks

   // A write must name a defined register
   a_cfg_addr_legal : assert property (
      @(posedge rvvi) disable iff (rst_i)
      cfg_we_i |-> (!$isunknown(cfg_addr_i) &&
                    cfg_addr_i inside {rvvi_trace_pkg::CFG_HALT_HOLD,
                                       rvvi_trace_pkg::CFG_CSR_CMP_EN})
   );

endmodule

`default_nettype wire

//--- filelist.f
design/rvvi_trace_pkg.sv
design/trace_cfg_regs.sv
design/retire_capture.sv
design/csr_merge.sv
design/halt_stretch.sv
design/fault_tracker.sv
design/irq_change_detect.sv
design/rvvi_trace_top.sv
sim/tb_rvvi_trace.sv

//--- run.sh
#!/bin/sh
# Compile and run the RVVI trace testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module tb_rvvi_trace -o tb_rvvi_trace
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_rvvi_trace 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- sim/tb_rvvi_trace.sv
////////////////////
// Testbench for the RVVI trace adapter
// Directed tests for retirement capture, CSR merge,
// halt stretching, fault tracking and interrupt changes
////////////////////

`default_nettype none

module tb_rvvi_trace;

   localparam int HOLD_W         = 4;
   localparam int TIMEOUT_CYCLES = 2000;
   // MSTATUS, MEPC and MIP off after reset
   localparam logic [7:0] CMP_EN_RESET = 8'h6E;

   logic                                                         rvvi;
   logic                                                         rst_i;
   logic                                                         rvfi_valid_i;
   logic [63:0]                                                  rvfi_order_i;
   logic [rvvi_trace_pkg::XLEN-1:0]                              rvfi_insn_i;
   logic [rvvi_trace_pkg::TRAP_W-1:0]                            rvfi_trap_i;
   logic                                                         rvfi_intr_intr_i;
   logic                                                         rvfi_intr_interrupt_i;
   logic [rvvi_trace_pkg::INTR_CAUSE_W-1:0]                      rvfi_intr_cause_i;
   logic [rvvi_trace_pkg::XLEN-1:0]                              rvfi_pc_rdata_i;
   logic [rvvi_trace_pkg::XLEN-1:0]                              rvfi_pc_wdata_i;
   logic [rvvi_trace_pkg::GPR_ADDR_W-1:0]                        rvfi_rd_addr_i;
   logic [rvvi_trace_pkg::XLEN-1:0]                              rvfi_rd_wdata_i;
   logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_wdata_i;
   logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_wmask_i;
   logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_rdata_i;
   logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_rmask_i;
   logic                                                         debug_req_i;
   logic [rvvi_trace_pkg::XLEN-1:0]                              irq_i;
   logic                                                         cfg_we_i;
   rvvi_trace_pkg::cfg_reg_e                                     cfg_addr_i;
   logic [rvvi_trace_pkg::XLEN-1:0]                              cfg_wdata_i;
   logic                                                         valid_o;
   logic [63:0]                                                  order_o;
   logic [rvvi_trace_pkg::XLEN-1:0]                              insn_o;
   logic [rvvi_trace_pkg::TRAP_W-1:0]                            trap_o;
   logic [rvvi_trace_pkg::XLEN-1:0]                              pc_rdata_o;
   logic [rvvi_trace_pkg::XLEN-1:0]                              pc_wdata_o;
   logic [rvvi_trace_pkg::XLEN-1:0]                              x_wdata_o;
   logic [rvvi_trace_pkg::NUM_GPR-1:0]                           x_wb_o;
   logic [rvvi_trace_pkg::NUM_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_value_o;
   logic [rvvi_trace_pkg::NUM_CSR-1:0]                           csr_wb_o;
   logic                                                         haltreq_o;
   logic                                                         nmi_o;
   rvvi_trace_pkg::nmi_cause_e                                   nmi_cause_o;
   logic                                                         ibus_fault_o;
   logic                                                         irq_change_o;
   logic [rvvi_trace_pkg::IRQ_MAP_W-1:0]                         irq_lines_o;

   logic [31:0]      lcg_state   = 32'hd719;
   int               cycle_count = 0;
   logic [7:0][31:0] csr_shadow;
   logic [7:0]       wb_model;

   rvvi_trace_top #(.HOLD_W(HOLD_W)) UUT (.*);

   initial begin
      rvvi = 1'b0;
      forever #2 rvvi = ~rvvi;
   end

   always @(posedge rvvi) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("STATUS: FAIL");
         $fatal(1, "timeout");
      end
   end

   ////////////////////
   // Helpers

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Per bit: a written bit wins, else a sampled read bit, else 0
   function automatic logic [31:0] merge_csr(input logic [31:0] wd, wm, rd, rm);
      logic [31:0] v;
      for (int b = 0; b < 32; b++) begin
         if (wm[b]) begin
            v[b] = wd[b];
         end else if (rm[b]) begin
            v[b] = rd[b];
         end else begin
            v[b] = 1'b0;
         end
      end
      return v;
   endfunction

   // Lines 3, 7, 11, then 16..31 from bit 0 up
   function automatic logic [18:0] map_irq(input logic [31:0] v);
      logic [18:0] m;
      m[0] = v[3];
      m[1] = v[7];
      m[2] = v[11];
      for (int k = 0; k < 16; k++) begin
         m[3 + k] = v[16 + k];
      end
      return m;
   endfunction

   task automatic tick();
      @(posedge rvvi);
      #1;
   endtask

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("[FAIL] t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
         $display("STATUS: FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic drive_idle();
      rvfi_valid_i          = 1'b0;
      rvfi_order_i          = '0;
      rvfi_insn_i           = '0;
      rvfi_trap_i           = '0;
      rvfi_intr_intr_i      = 1'b0;
      rvfi_intr_interrupt_i = 1'b0;
      rvfi_intr_cause_i     = '0;
      rvfi_pc_rdata_i       = '0;
      rvfi_pc_wdata_i       = '0;
      rvfi_rd_addr_i        = '0;
      rvfi_rd_wdata_i       = '0;
      csr_wdata_i           = '0;
      csr_wmask_i           = '0;
      csr_rdata_i           = '0;
      csr_rmask_i           = '0;
   endtask

   // No retirement during the write
   task automatic cfg_write(input rvvi_trace_pkg::cfg_reg_e addr, input logic [31:0] data);
      rvfi_valid_i = 1'b0;
      cfg_we_i     = 1'b1;
      cfg_addr_i   = addr;
      cfg_wdata_i  = data;
      tick();
      cfg_we_i     = 1'b0;
   endtask

   ////////////////////
   // Tests

   task automatic test_reset_state();
      check("valid_o", 0, valid_o);
      check("x_wb_o", 0, x_wb_o);
      for (int i = 0; i < 8; i++) begin
         check($sformatf("csr_value_o[%0d]", i), 0, csr_value_o[i]);
      end
      check("csr_wb_o", 0, csr_wb_o);
      check("haltreq_o", 0, haltreq_o);
      check("nmi_o", 0, nmi_o);
      check("ibus_fault_o", 0, ibus_fault_o);
      check("irq_change_o", 0, irq_change_o);
      check("irq_lines_o", 0, irq_lines_o);
   endtask

   task automatic test_retire();
      logic [31:0] exp_wb;
      for (int n = 0; n < 16; n++) begin
         rvfi_valid_i    = (n % 4 != 3);
         rvfi_order_i    = {next_rand(), next_rand()};
         rvfi_insn_i     = next_rand();
         rvfi_trap_i     = 14'(next_rand());
         rvfi_pc_rdata_i = next_rand();
         rvfi_pc_wdata_i = next_rand();
         rvfi_rd_wdata_i = next_rand();
         rvfi_rd_addr_i  = (n == 2) ? 5'd0 : 5'(next_rand());
         tick();
         exp_wb = (rvfi_valid_i && rvfi_rd_addr_i != 0) ? (32'd1 << rvfi_rd_addr_i) : 32'd0;
         check("valid_o", rvfi_valid_i, valid_o);
         check("order_o", rvfi_order_i, order_o);
         check("insn_o", rvfi_insn_i, insn_o);
         check("trap_o", rvfi_trap_i, trap_o);
         check("pc_rdata_o", rvfi_pc_rdata_i, pc_rdata_o);
         check("pc_wdata_o", rvfi_pc_wdata_i, pc_wdata_o);
         check("x_wdata_o", rvfi_rd_wdata_i, x_wdata_o);
         check("x_wb_o", exp_wb, x_wb_o);
      end
      drive_idle();
   endtask

   task automatic test_fault();
      // Load NMI, then an idle cycle with another cause
      rvfi_valid_i          = 1'b1;
      rvfi_intr_intr_i      = 1'b1;
      rvfi_intr_interrupt_i = 1'b1;
      rvfi_intr_cause_i     = 11'd1024;
      tick();
      check("nmi_o", 1, nmi_o);
      check("nmi_cause_o", 1024, nmi_cause_o);
      rvfi_valid_i      = 1'b0;
      rvfi_intr_cause_i = 11'd3;
      tick();
      check("nmi_o", 1, nmi_o);
      rvfi_valid_i      = 1'b1;
      rvfi_intr_cause_i = 11'd1025;
      tick();
      check("nmi_cause_o", 1025, nmi_cause_o);
      rvfi_intr_intr_i      = 1'b0;
      rvfi_intr_interrupt_i = 1'b0;
      rvfi_intr_cause_i     = '0;
      tick();
      check("nmi_o", 0, nmi_o);
      check("nmi_cause_o", 1025, nmi_cause_o);
      // Fetch fault: cause 48 with exception and trap set
      rvfi_trap_i = {2'b00, 3'b000, 6'd48, 1'b0, 1'b1, 1'b1};
      tick();
      check("ibus_fault_o", 1, ibus_fault_o);
      rvfi_valid_i = 1'b0;
      rvfi_trap_i  = '0;
      tick();
      check("ibus_fault_o", 1, ibus_fault_o);
      rvfi_valid_i = 1'b1;
      tick();
      check("ibus_fault_o", 0, ibus_fault_o);
      drive_idle();
   endtask

   task automatic test_csr();
      logic [7:0]  cmp_en;
      logic [31:0] merged;
      cmp_en     = CMP_EN_RESET;
      csr_shadow = '0;
      wb_model   = '0;
      for (int r = 0; r < 7; r++) begin
         if (r == 5) begin
            cfg_write(rvvi_trace_pkg::CFG_CSR_CMP_EN, 32'hFF);
            cmp_en = 8'hFF;
         end
         for (int i = 0; i < 8; i++) begin
            csr_wdata_i[i] = next_rand();
            csr_wmask_i[i] = next_rand();
            csr_rdata_i[i] = next_rand();
            csr_rmask_i[i] = next_rand();
            // Some slots rewrite their stored value
            if ((r + i) % 3 == 0) begin
               csr_wdata_i[i] = csr_shadow[i];
               csr_wmask_i[i] = '1;
            end
         end
         if (r >= 5) begin
            csr_wdata_i[7] = csr_shadow[7] ^ 32'h1;
            csr_wmask_i[7] = '1;
         end
         rvfi_valid_i = (r != 3);
         tick();
         if (rvfi_valid_i) begin
            for (int i = 0; i < 8; i++) begin
               merged      = merge_csr(csr_wdata_i[i], csr_wmask_i[i],
                                       csr_rdata_i[i], csr_rmask_i[i]);
               wb_model[i] = (merged != csr_shadow[i]) && cmp_en[i];
               csr_shadow[i] = merged;
            end
         end
         for (int i = 0; i < 8; i++) begin
            check($sformatf("csr_value_o[%0d]", i), csr_shadow[i], csr_value_o[i]);
         end
         check("csr_wb_o", wb_model, csr_wb_o);
      end
      check("csr_wb_o[MIP]", 1, csr_wb_o[7]);
      drive_idle();
   endtask

   task automatic check_halt(input int hold);
      debug_req_i = 1'b1;
      tick();
      check("haltreq_o", 1, haltreq_o);
      tick();
      check("haltreq_o", 1, haltreq_o);
      debug_req_i = 1'b0;
      for (int c = 0; c < hold; c++) begin
         tick();
         check("haltreq_o", 1, haltreq_o);
      end
      tick();
      check("haltreq_o", 0, haltreq_o);
   endtask

   task automatic test_irq();
      for (int n = 0; n < 3; n++) begin
         irq_i = irq_i ^ (next_rand() | 32'h8);
         tick();
         check("irq_change_o", 1, irq_change_o);
         check("irq_lines_o", map_irq(irq_i), irq_lines_o);
         for (int c = 0; c < 2; c++) begin
            tick();
            check("irq_change_o", 0, irq_change_o);
            check("irq_lines_o", map_irq(irq_i), irq_lines_o);
         end
      end
   endtask

   ////////////////////
   // Sequence

   initial begin
      rst_i       = 1'b1;
      debug_req_i = 1'b0;
      irq_i       = '0;
      cfg_we_i    = 1'b0;
      cfg_addr_i  = rvvi_trace_pkg::CFG_HALT_HOLD;
      cfg_wdata_i = '0;
      drive_idle();
      repeat (8) @(posedge rvvi);
      #1;
      rst_i = 1'b0;
      test_reset_state();
      test_retire();
      test_fault();
      test_csr();
      check_halt(5);
      cfg_write(rvvi_trace_pkg::CFG_HALT_HOLD, 32'd2);
      check_halt(2);
      test_irq();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire
